// ==== design/sad_pkg.sv ====
package sad_pkg;

    // host register address
    typedef logic [7:0] reg_addr_t;

    // register map
    // reference bytes, selected by reg_bytecnt
    localparam reg_addr_t ADDR_REFERENCE = 8'd0;
    // threshold, little-endian
    localparam reg_addr_t ADDR_THRESHOLD = 8'd1;
    // byte 0 bit 0 triggered, bytes 1..2 trigger count, write clears
    localparam reg_addr_t ADDR_STATUS = 8'd2;
    localparam reg_addr_t ADDR_MULTIPLE_TRIGGERS = 8'd3;
    // read only
    localparam reg_addr_t ADDR_REF_SAMPLES = 8'd4;
    localparam reg_addr_t ADDR_VERSION = 8'd5;

    // top 2 bits design code, low 6 bits trigger latency in cycles
    localparam logic [7:0] VERSION_CODE = {2'b10, 6'd4};

    localparam int TRIGGER_COUNT_W = 16;

    // counter width for n samples, never below 1
    function automatic int clog2_min1(input int n);
        int w;
        w = $clog2(n);
        if (w < 1) begin
            w = 1;
        end
        return w;
    endfunction

endpackage

// ==== design/sad_reg_bank.sv ====
`timescale 1ns/1ps

module sad_reg_bank #(
    parameter int pREF_SAMPLES = 8,
    parameter int pBITS_PER_SAMPLE = 8,
    parameter int pSAD_COUNTER_WIDTH = 16,
    parameter int pBYTECNT_SIZE = 7
) (
    input  logic                                     adc_sampleclk,
    input  logic                                     reset,
    input  sad_pkg::reg_addr_t                       reg_address,
    input  logic [pBYTECNT_SIZE-1:0]                 reg_bytecnt,
    input  logic [7:0]                               reg_datai,
    input  logic                                     reg_read,
    input  logic                                     reg_write,
    input  logic                                     triggered,
    input  logic [sad_pkg::TRIGGER_COUNT_W-1:0]      trigger_count,
    output logic [7:0]                               reg_datao,
    output logic [pREF_SAMPLES*pBITS_PER_SAMPLE-1:0] reference,
    output logic [pSAD_COUNTER_WIDTH-1:0]            threshold,
    output logic                                     multiple_triggers,
    output logic                                     clear_status
);

    localparam int REF_BYTES = (pREF_SAMPLES * pBITS_PER_SAMPLE + 7) / 8;
    localparam int THR_BYTES = (pSAD_COUNTER_WIDTH + 7) / 8;
    localparam int STATUS_BYTES = (sad_pkg::TRIGGER_COUNT_W + 8) / 8;

    logic [REF_BYTES*8-1:0] ref_bytes;
    logic [THR_BYTES*8-1:0] thr_bytes;
    logic [STATUS_BYTES*8-1:0] status_word;
    logic [15:0] ref_samples_word;

    assign reference = ref_bytes[pREF_SAMPLES*pBITS_PER_SAMPLE-1:0];
    assign threshold = thr_bytes[pSAD_COUNTER_WIDTH-1:0];
    assign status_word = {trigger_count, 7'b0, triggered};
    assign ref_samples_word = 16'(pREF_SAMPLES);

    // host writes
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_bytes <= '0;
            thr_bytes <= '0;
            multiple_triggers <= 1'b0;
            clear_status <= 1'b0;
        end else begin
            clear_status <= reg_write && (reg_address == sad_pkg::ADDR_STATUS);
            if (reg_write) begin
                case (reg_address)
                    sad_pkg::ADDR_REFERENCE: begin
                        if (reg_bytecnt < REF_BYTES) begin
                            ref_bytes[reg_bytecnt*8 +: 8] <= reg_datai;
                        end
                    end
                    sad_pkg::ADDR_THRESHOLD: begin
                        if (reg_bytecnt < THR_BYTES) begin
                            thr_bytes[reg_bytecnt*8 +: 8] <= reg_datai;
                        end
                    end
                    sad_pkg::ADDR_MULTIPLE_TRIGGERS: multiple_triggers <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // reads are combinational, zero when idle
    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                sad_pkg::ADDR_REFERENCE: begin
                    if (reg_bytecnt < REF_BYTES) begin
                        reg_datao = ref_bytes[reg_bytecnt*8 +: 8];
                    end
                end
                sad_pkg::ADDR_THRESHOLD: begin
                    if (reg_bytecnt < THR_BYTES) begin
                        reg_datao = thr_bytes[reg_bytecnt*8 +: 8];
                    end
                end
                sad_pkg::ADDR_STATUS: begin
                    if (reg_bytecnt < STATUS_BYTES) begin
                        reg_datao = status_word[reg_bytecnt*8 +: 8];
                    end
                end
                sad_pkg::ADDR_MULTIPLE_TRIGGERS: reg_datao = {7'b0, multiple_triggers};
                sad_pkg::ADDR_REF_SAMPLES: begin
                    if (reg_bytecnt < 2) begin
                        reg_datao = ref_samples_word[reg_bytecnt*8 +: 8];
                    end
                end
                sad_pkg::ADDR_VERSION: reg_datao = sad_pkg::VERSION_CODE;
                default: reg_datao = 8'h00;
            endcase
        end
    end

    // host never reads and writes in the same cycle
    assert property (@(posedge adc_sampleclk) disable iff (reset) !(reg_read && reg_write));

endmodule

// ==== design/sad_sample_front.sv ====
`timescale 1ns/1ps

module sad_sample_front #(
    parameter int pREF_SAMPLES = 8,
    parameter int pBITS_PER_SAMPLE = 8
) (
    input  logic                                         adc_sampleclk,
    input  logic                                         reset,
    input  logic [pBITS_PER_SAMPLE-1:0]                  adc_datain,
    input  logic                                         armed_and_ready,
    input  logic                                         active,
    input  logic                                         xadc_error,
    output logic [pBITS_PER_SAMPLE-1:0]                  sample,
    output logic                                         enable,
    output logic                                         arm_pulse,
    output logic [sad_pkg::clog2_min1(pREF_SAMPLES)-1:0] phase,
    output logic                                         window_ready
);

    localparam int PHASE_W = sad_pkg::clog2_min1(pREF_SAMPLES);
    localparam int WARM_W = sad_pkg::clog2_min1(pREF_SAMPLES + 1);

    logic en_next;
    logic armed_prev;
    logic [WARM_W-1:0] warm_cnt;

    assign en_next = armed_and_ready && active && !xadc_error;
    // enable and the counters describe the sample register beside them
    assign window_ready = (warm_cnt == WARM_W'(pREF_SAMPLES));

    always_ff @(posedge adc_sampleclk) begin
        sample <= adc_datain;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            enable <= 1'b0;
            armed_prev <= 1'b0;
            arm_pulse <= 1'b0;
        end else begin
            enable <= en_next;
            armed_prev <= armed_and_ready;
            arm_pulse <= armed_and_ready && !armed_prev;
        end
    end

    // window phase, first enabled sample gets 0
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !en_next || !enable) begin
            phase <= '0;
        end else if (phase == PHASE_W'(pREF_SAMPLES - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // warm-up, saturates once a full window is in
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !en_next) begin
            warm_cnt <= '0;
        end else if (warm_cnt != WARM_W'(pREF_SAMPLES)) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

endmodule

// ==== design/sad_accumulator_array.sv ====
`timescale 1ns/1ps

module sad_accumulator_array #(
    parameter int pREF_SAMPLES = 8,
    parameter int pBITS_PER_SAMPLE = 8,
    parameter int pSAD_COUNTER_WIDTH = 16
) (
    input  logic                                         adc_sampleclk,
    input  logic                                         reset,
    input  logic [pBITS_PER_SAMPLE-1:0]                  sample,
    input  logic                                         enable,
    input  logic [sad_pkg::clog2_min1(pREF_SAMPLES)-1:0] phase,
    input  logic                                         window_ready,
    input  logic [pREF_SAMPLES*pBITS_PER_SAMPLE-1:0]     reference,
    output logic [pSAD_COUNTER_WIDTH-1:0]                window_sad,
    output logic                                         window_valid
);

    localparam int PHASE_W = sad_pkg::clog2_min1(pREF_SAMPLES);

    logic [pBITS_PER_SAMPLE-1:0] diff [pREF_SAMPLES];
    logic [pSAD_COUNTER_WIDTH-1:0] acc [pREF_SAMPLES];

    logic [PHASE_W-1:0] phase_d1;
    logic en_d1;
    logic ready_d1;
    logic [PHASE_W-1:0] done_idx;

    // control delays alongside the two data stages
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            phase_d1 <= '0;
            en_d1 <= 1'b0;
            ready_d1 <= 1'b0;
            done_idx <= '0;
            window_valid <= 1'b0;
        end else begin
            phase_d1 <= phase;
            en_d1 <= enable;
            ready_d1 <= window_ready;
            // accumulator after the current phase closes its window
            if (phase_d1 == PHASE_W'(pREF_SAMPLES - 1)) begin
                done_idx <= '0;
            end else begin
                done_idx <= phase_d1 + 1'b1;
            end
            window_valid <= ready_d1;
        end
    end

    for (genvar i = 0; i < pREF_SAMPLES; i++) begin : gen_acc
        logic [PHASE_W-1:0] ref_idx;
        logic [pBITS_PER_SAMPLE-1:0] ref_sample;

        // offset of this sample inside accumulator i's window
        always_comb begin
            if (phase >= PHASE_W'(i)) begin
                ref_idx = phase - PHASE_W'(i);
            end else begin
                ref_idx = phase + PHASE_W'(pREF_SAMPLES - i);
            end
        end

        assign ref_sample = reference[ref_idx*pBITS_PER_SAMPLE +: pBITS_PER_SAMPLE];

        // stage 1 absolute difference
        always_ff @(posedge adc_sampleclk) begin
            if (sample > ref_sample) begin
                diff[i] <= sample - ref_sample;
            end else begin
                diff[i] <= ref_sample - sample;
            end
        end

        // stage 2 accumulate, MSB set means saturated
        always_ff @(posedge adc_sampleclk) begin
            if (!en_d1) begin
                acc[i] <= '0;
            end else if (phase_d1 == PHASE_W'(i)) begin
                acc[i] <= pSAD_COUNTER_WIDTH'(diff[i]);
            end else if (!acc[i][pSAD_COUNTER_WIDTH-1]) begin
                acc[i] <= acc[i] + pSAD_COUNTER_WIDTH'(diff[i]);
            end
        end
    end

    assign window_sad = acc[done_idx];

    // a reported window was fed while the front was enabled
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        window_valid |-> $past(enable, 2));

endmodule

// ==== design/sad_trigger_out.sv ====
`timescale 1ns/1ps

module sad_trigger_out #(
    parameter int pREF_SAMPLES = 8,
    parameter int pSAD_COUNTER_WIDTH = 16
) (
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic [pSAD_COUNTER_WIDTH-1:0]       window_sad,
    input  logic                                window_valid,
    input  logic [pSAD_COUNTER_WIDTH-1:0]       threshold,
    input  logic                                multiple_triggers,
    input  logic                                clear_status,
    input  logic                                arm_pulse,
    output logic                                trigger,
    output logic                                triggered,
    output logic [sad_pkg::TRIGGER_COUNT_W-1:0] trigger_count
);

    logic hit;
    logic trigger_prev;
    logic suppress;

    assign suppress = triggered && !multiple_triggers;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            hit <= 1'b0;
            trigger <= 1'b0;
            trigger_prev <= 1'b0;
        end else begin
            hit <= window_valid && (window_sad <= threshold);
            trigger <= hit && !suppress;
            trigger_prev <= trigger;
        end
    end

    // status flag and count of trigger rising edges, clear wins
    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_status || arm_pulse) begin
            triggered <= 1'b0;
            trigger_count <= '0;
        end else if (trigger && !trigger_prev) begin
            triggered <= 1'b1;
            if (!(&trigger_count)) begin
                trigger_count <= trigger_count + 1'b1;
            end
        end
    end

    // single-trigger mode only lets an already running pulse continue
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        (trigger && triggered && !multiple_triggers)
        |-> ($past(trigger) || $past(multiple_triggers)));

endmodule

// ==== design/sad_trigger_top.sv ====
`timescale 1ns/1ps

module sad_trigger_top #(
    parameter int pREF_SAMPLES = 8,
    parameter int pBITS_PER_SAMPLE = 8,
    parameter int pSAD_COUNTER_WIDTH = 16,
    parameter int pBYTECNT_SIZE = 7
) (
    input  logic                          reset,
    input  logic                          adc_sampleclk,
    input  logic [pBITS_PER_SAMPLE-1:0]   adc_datain,
    input  logic                          armed_and_ready,
    input  logic                          active,
    input  logic                          xadc_error,
    input  sad_pkg::reg_addr_t            reg_address,
    input  logic [pBYTECNT_SIZE-1:0]      reg_bytecnt,
    input  logic [7:0]                    reg_datai,
    input  logic                          reg_read,
    input  logic                          reg_write,
    output logic [7:0]                    reg_datao,
    output logic                          trigger
);

    logic [pBITS_PER_SAMPLE-1:0] sample;
    logic enable;
    logic arm_pulse;
    logic [sad_pkg::clog2_min1(pREF_SAMPLES)-1:0] phase;
    logic window_ready;

    logic [pREF_SAMPLES*pBITS_PER_SAMPLE-1:0] reference;
    logic [pSAD_COUNTER_WIDTH-1:0] threshold;
    logic multiple_triggers;
    logic clear_status;

    logic [pSAD_COUNTER_WIDTH-1:0] window_sad;
    logic window_valid;

    logic triggered;
    logic [sad_pkg::TRIGGER_COUNT_W-1:0] trigger_count;

    sad_reg_bank #(
        .pREF_SAMPLES       (pREF_SAMPLES),
        .pBITS_PER_SAMPLE   (pBITS_PER_SAMPLE),
        .pSAD_COUNTER_WIDTH (pSAD_COUNTER_WIDTH),
        .pBYTECNT_SIZE      (pBYTECNT_SIZE)
    ) u_reg_bank (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .reg_address        (reg_address),
        .reg_bytecnt        (reg_bytecnt),
        .reg_datai          (reg_datai),
        .reg_read           (reg_read),
        .reg_write          (reg_write),
        .triggered          (triggered),
        .trigger_count      (trigger_count),
        .reg_datao          (reg_datao),
        .reference          (reference),
        .threshold          (threshold),
        .multiple_triggers  (multiple_triggers),
        .clear_status       (clear_status)
    );

    sad_sample_front #(
        .pREF_SAMPLES       (pREF_SAMPLES),
        .pBITS_PER_SAMPLE   (pBITS_PER_SAMPLE)
    ) u_sample_front (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .adc_datain         (adc_datain),
        .armed_and_ready    (armed_and_ready),
        .active             (active),
        .xadc_error         (xadc_error),
        .sample             (sample),
        .enable             (enable),
        .arm_pulse          (arm_pulse),
        .phase              (phase),
        .window_ready       (window_ready)
    );

    sad_accumulator_array #(
        .pREF_SAMPLES       (pREF_SAMPLES),
        .pBITS_PER_SAMPLE   (pBITS_PER_SAMPLE),
        .pSAD_COUNTER_WIDTH (pSAD_COUNTER_WIDTH)
    ) u_accumulator_array (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .sample             (sample),
        .enable             (enable),
        .phase              (phase),
        .window_ready       (window_ready),
        .reference          (reference),
        .window_sad         (window_sad),
        .window_valid       (window_valid)
    );

    sad_trigger_out #(
        .pREF_SAMPLES       (pREF_SAMPLES),
        .pSAD_COUNTER_WIDTH (pSAD_COUNTER_WIDTH)
    ) u_trigger_out (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .window_sad         (window_sad),
        .window_valid       (window_valid),
        .threshold          (threshold),
        .multiple_triggers  (multiple_triggers),
        .clear_status       (clear_status),
        .arm_pulse          (arm_pulse),
        .trigger            (trigger),
        .triggered          (triggered),
        .trigger_count      (trigger_count)
    );

endmodule

// ==== bench/sad_trigger_tests.svh ====
task automatic register_readback();
    logic [7:0] value;
    for (int k = 0; k < REF_SAMPLES; k++) begin
        write_reg(sad_pkg::ADDR_REFERENCE, k, REF_WAVE[k*8 +: 8]);
    end
    write_reg(sad_pkg::ADDR_THRESHOLD, 0, 8'h34);
    write_reg(sad_pkg::ADDR_THRESHOLD, 1, 8'h12);
    write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h01);
    for (int k = 0; k < REF_SAMPLES; k++) begin
        read_reg(sad_pkg::ADDR_REFERENCE, k, value);
        check_value("reference byte", value, REF_WAVE[k*8 +: 8]);
    end
    read_reg(sad_pkg::ADDR_THRESHOLD, 0, value);
    check_value("threshold byte 0", value, 8'h34);
    read_reg(sad_pkg::ADDR_THRESHOLD, 1, value);
    check_value("threshold byte 1", value, 8'h12);
    read_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, value);
    check_value("multiple_triggers", value, 8'h01);
    read_reg(sad_pkg::ADDR_REF_SAMPLES, 0, value);
    check_value("ref_samples", value, REF_SAMPLES);
    read_reg(sad_pkg::ADDR_VERSION, 0, value);
    check_value("version", value, sad_pkg::VERSION_CODE);
    // low bits carry the trigger latency
    check_value("version latency", value[5:0], 4);
endtask

task automatic single_match();
    disarm();
    write_reg(sad_pkg::ADDR_THRESHOLD, 0, 8'h00);
    write_reg(sad_pkg::ADDR_THRESHOLD, 1, 8'h00);
    write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h00);
    rearm();
    stream_random(20);
    stream_copy(0, 8'd0);
    wait_for_trigger(10);
    stream_random(12);
    idle(6);
    check_status(1'b1, 16'd1);
endtask

task automatic threshold_boundary();
    logic [7:0] noise;
    disarm();
    write_reg(sad_pkg::ADDR_THRESHOLD, 0, 8'd16);
    write_reg(sad_pkg::ADDR_THRESHOLD, 1, 8'h00);
    write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h01);
    rearm();
    stream_random(24);
    // SAD exactly at the threshold, then one above
    stream_copy(3, 8'd16);
    stream_random(12);
    stream_copy(3, 8'd17);
    stream_random(12);
    // near copies, some land under the threshold
    repeat (6) begin
        for (int k = 0; k < REF_SAMPLES; k++) begin
            next_random_byte(noise);
            drive_sample(ref_model[k] ^ (noise & 8'h07));
        end
        stream_random(10);
    end
    stream_random(40);
    idle(8);
endtask

task automatic repeated_matches();
    for (int m = 0; m < 2; m++) begin
        disarm();
        write_reg(sad_pkg::ADDR_THRESHOLD, 0, 8'h00);
        write_reg(sad_pkg::ADDR_THRESHOLD, 1, 8'h00);
        write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'(m));
        rearm();
        stream_random(16);
        stream_copy(0, 8'd0);
        stream_random(20);
        stream_copy(0, 8'd0);
        stream_random(12);
        idle(6);
        // single mode counts the first copy only
        check_status(1'b1, 16'(m + 1));
    end
endtask

task automatic clear_and_rearm();
    disarm();
    write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h00);
    rearm();
    stream_random(12);
    stream_copy(0, 8'd0);
    wait_for_trigger(10);
    idle(4);
    check_status(1'b1, 16'd1);
    write_reg(sad_pkg::ADDR_STATUS, 0, 8'h00);
    idle(2);
    check_status(1'b0, 16'd0);

    // copy cut by an XADC error
    stream_random(12);
    for (int k = 0; k < REF_SAMPLES; k++) begin
        drive_sample(ref_model[k]);
        if (k == 3) begin
            xadc_error = 1'b1;
        end
    end
    @(negedge adc_sampleclk);
    xadc_error = 1'b0;
    stream_random(16);
    idle(6);
    check_status(1'b0, 16'd0);

    // copy cut by dropping armed_and_ready
    for (int k = 0; k < REF_SAMPLES; k++) begin
        drive_sample(ref_model[k]);
        if (k == 5) begin
            armed_and_ready = 1'b0;
        end
    end
    rearm();
    stream_random(12);
    idle(6);
    check_status(1'b0, 16'd0);

    stream_copy(0, 8'd0);
    wait_for_trigger(10);
    idle(4);
    check_status(1'b1, 16'd1);
    // new arming edge clears the count
    disarm();
    rearm();
    idle(4);
    check_status(1'b0, 16'd0);
endtask

// ==== bench/tb_sad_trigger.sv ====
`timescale 1ns/1ps

module tb_sad_trigger;

    localparam int REF_SAMPLES = 8;
    localparam int HALF_PERIOD = 50;
    localparam int WATCHDOG_NS = 1_000_000;
    // reference waveform, byte k is sample k
    localparam logic [63:0] REF_WAVE = 64'h7E10_99C4_30F0_05A2;

    logic reset;
    logic adc_sampleclk;
    logic [7:0] adc_datain;
    logic armed_and_ready;
    logic active;
    logic xadc_error;
    sad_pkg::reg_addr_t reg_address;
    logic [6:0] reg_bytecnt;
    logic [7:0] reg_datai;
    logic reg_read;
    logic reg_write;
    logic [7:0] reg_datao;
    logic trigger;

    int checks;
    int errors;
    int cyc;
    int run_len;
    logic [15:0] lfsr_state;

    // model state, fed from host writes and driven samples
    logic [7:0] ref_model [REF_SAMPLES];
    logic [7:0] hist [REF_SAMPLES];
    logic [15:0] thr_model;
    logic multi_model;
    logic triggered_model;
    // expected trigger level, indexed by cycle
    logic trig_ring [16];

    sad_trigger_top DUT (
        .reset           (reset),
        .adc_sampleclk   (adc_sampleclk),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .xadc_error      (xadc_error),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .reg_datao       (reg_datao),
        .trigger         (trigger)
    );

    always #HALF_PERIOD adc_sampleclk = ~adc_sampleclk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // window SAD, summation stops once the MSB is set
    function automatic logic [15:0] model_sad();
        logic [15:0] acc;
        logic [7:0] d;
        acc = '0;
        for (int k = 0; k < REF_SAMPLES; k++) begin
            d = (hist[k] > ref_model[k]) ? hist[k] - ref_model[k] : ref_model[k] - hist[k];
            if (!acc[15]) begin
                acc = acc + 16'(d);
            end
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic next_random_byte(output logic [7:0] value);
        value = '0;
        repeat (8) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    // what the front end captures at each rising edge
    always @(posedge adc_sampleclk) begin
        cyc = cyc + 1;
        if (reset || !(armed_and_ready && active && !xadc_error)) begin
            run_len = 0;
        end else begin
            for (int k = 0; k < REF_SAMPLES - 1; k++) begin
                hist[k] = hist[k + 1];
            end
            hist[REF_SAMPLES - 1] = adc_datain;
            if (run_len < REF_SAMPLES) begin
                run_len++;
            end
            if (run_len == REF_SAMPLES && model_sad() <= thr_model &&
                    (multi_model || !triggered_model)) begin
                // trigger follows the last window sample by four edges
                trig_ring[(cyc + 4) % 16] = 1'b1;
                triggered_model = 1'b1;
            end
        end
    end

    always @(negedge adc_sampleclk) begin
        if (!reset) begin
            check_value("trigger", trigger, trig_ring[cyc % 16]);
        end
        trig_ring[cyc % 16] = 1'b0;
    end

    task automatic write_reg(input sad_pkg::reg_addr_t addr, input int idx,
                             input logic [7:0] data);
        @(negedge adc_sampleclk);
        reg_address = addr;
        reg_bytecnt = 7'(idx);
        reg_datai = data;
        reg_write = 1'b1;
        case (addr)
            sad_pkg::ADDR_REFERENCE: ref_model[idx] = data;
            sad_pkg::ADDR_THRESHOLD: thr_model[idx*8 +: 8] = data;
            sad_pkg::ADDR_STATUS: triggered_model = 1'b0;
            sad_pkg::ADDR_MULTIPLE_TRIGGERS: multi_model = data[0];
            default: ;
        endcase
        @(negedge adc_sampleclk);
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input sad_pkg::reg_addr_t addr, input int idx,
                            output logic [7:0] data);
        @(negedge adc_sampleclk);
        reg_address = addr;
        reg_bytecnt = 7'(idx);
        reg_read = 1'b1;
        // read data is combinational, settled well before the next edge
        #(HALF_PERIOD / 2);
        data = reg_datao;
        @(negedge adc_sampleclk);
        reg_read = 1'b0;
    endtask

    task automatic check_status(input logic exp_triggered, input logic [15:0] exp_count);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        read_reg(sad_pkg::ADDR_STATUS, 0, b0);
        read_reg(sad_pkg::ADDR_STATUS, 1, b1);
        read_reg(sad_pkg::ADDR_STATUS, 2, b2);
        check_value("status triggered", b0, {7'b0, exp_triggered});
        check_value("status trigger_count", {b2, b1}, exp_count);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge adc_sampleclk);
    endtask

    task automatic drive_sample(input logic [7:0] value);
        @(negedge adc_sampleclk);
        adc_datain = value;
    endtask

    task automatic stream_random(input int n);
        logic [7:0] value;
        repeat (n) begin
            next_random_byte(value);
            drive_sample(value);
        end
    endtask

    // reference copy with sample bump_idx raised by bump
    task automatic stream_copy(input int bump_idx, input logic [7:0] bump);
        for (int k = 0; k < REF_SAMPLES; k++) begin
            drive_sample(k == bump_idx ? ref_model[k] + bump : ref_model[k]);
        end
    endtask

    task automatic disarm();
        @(negedge adc_sampleclk);
        armed_and_ready = 1'b0;
        idle(6);
    endtask

    task automatic rearm();
        @(negedge adc_sampleclk);
        armed_and_ready = 1'b1;
        active = 1'b1;
        xadc_error = 1'b0;
        triggered_model = 1'b0;
    endtask

    task automatic wait_for_trigger(input int max_cycles);
        int n;
        n = 0;
        while (trigger !== 1'b1 && n < max_cycles) begin
            @(negedge adc_sampleclk);
            n++;
        end
        if (trigger !== 1'b1) begin
            errors++;
            $display("trigger did not rise within %0d cycles at %0t", max_cycles, $time);
        end
    endtask

    `include "sad_trigger_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran out of time before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        adc_sampleclk = 1'b0;
        reset = 1'b1;
        adc_datain = '0;
        armed_and_ready = 1'b0;
        active = 1'b0;
        xadc_error = 1'b0;
        reg_address = '0;
        reg_bytecnt = '0;
        reg_datai = '0;
        reg_read = 1'b0;
        reg_write = 1'b0;
        checks = 0;
        errors = 0;
        cyc = 0;
        run_len = 0;
        lfsr_state = 16'd3;
        thr_model = '0;
        multi_model = 1'b0;
        triggered_model = 1'b0;
        for (int k = 0; k < 16; k++) begin
            trig_ring[k] = 1'b0;
        end
        for (int k = 0; k < REF_SAMPLES; k++) begin
            ref_model[k] = '0;
            hist[k] = '0;
        end
        repeat (8) @(negedge adc_sampleclk);
        reset = 1'b0;

        register_readback();
        single_match();
        threshold_boundary();
        repeated_matches();
        clear_and_rearm();
        idle(8);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sad_trigger.f ====
+incdir+bench
design/sad_pkg.sv
design/sad_reg_bank.sv
design/sad_sample_front.sv
design/sad_accumulator_array.sv
design/sad_trigger_out.sv
design/sad_trigger_top.sv
bench/tb_sad_trigger.sv

// ==== Bender.yml ====
package:
  name: sad_trigger

sources:
  - files:
      - design/sad_pkg.sv
      - design/sad_reg_bank.sv
      - design/sad_sample_front.sv
      - design/sad_accumulator_array.sv
      - design/sad_trigger_out.sv
      - design/sad_trigger_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_sad_trigger.sv
